//--- verilog/ooo_pkg.sv
package ooo_pkg;

    localparam int XLEN          = 32;
    localparam int NUM_ARCH_REGS = 32;
    localparam int REG_SEL       = 5;
    localparam int NUM_RRF       = 8;
    localparam int RRF_SEL       = 3;
    localparam int RS_ENTRIES    = 4;
    localparam int RS_SEL        = 2;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_e;

    typedef enum logic {
        SRC_B_REG = 1'b0,
        SRC_B_IMM = 1'b1
    } src_b_sel_e;

    typedef enum logic {
        IDLE  = 1'b0,
        ACKED = 1'b1
    } dispatch_state_e;

    typedef struct packed {
        alu_op_e            op;
        logic [REG_SEL-1:0] rd;
        logic [REG_SEL-1:0] rs1;
        logic [REG_SEL-1:0] rs2;
        src_b_sel_e         src_b_sel;
        logic [XLEN-1:0]    imm;
        logic               wr_reg;
    } uop_t;

    typedef struct packed {
        logic               ready;
        logic [RRF_SEL-1:0] tag;
        logic [XLEN-1:0]    value;
    } operand_t;

    typedef struct packed {
        alu_op_e            op;
        src_b_sel_e         src_b_sel;
        logic [XLEN-1:0]    imm;
        operand_t           src1;
        operand_t           src2;
        logic [RRF_SEL-1:0] dst_tag;
    } rs_entry_t;

    // result broadcast
    typedef struct packed {
        logic               valid;
        logic [RRF_SEL-1:0] tag;
        logic [XLEN-1:0]    data;
    } wb_t;

    typedef struct packed {
        logic               valid;
        logic               wen;
        logic [REG_SEL-1:0] rd;
        logic [XLEN-1:0]    data;
    } commit_t;

endpackage

//--- verilog/arch_reg_file.sv
`timescale 1ns/1ps

module arch_reg_file (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        alloc_i,
    input  ooo_pkg::uop_t               uop_i,
    input  logic [ooo_pkg::RRF_SEL-1:0] alloc_tag_i,
    input  ooo_pkg::commit_t            commit_i,
    input  logic [ooo_pkg::RRF_SEL-1:0] head_tag_i,
    input  ooo_pkg::operand_t           rrf_src1_i,
    input  ooo_pkg::operand_t           rrf_src2_i,
    output logic [ooo_pkg::RRF_SEL-1:0] src1_tag_o,
    output logic [ooo_pkg::RRF_SEL-1:0] src2_tag_o,
    output ooo_pkg::operand_t           src1_o,
    output ooo_pkg::operand_t           src2_o
);

    import ooo_pkg::*;

    logic [XLEN-1:0]          regs [NUM_ARCH_REGS];
    logic [RRF_SEL-1:0]       tags [NUM_ARCH_REGS];
    logic [NUM_ARCH_REGS-1:0] busy;
    logic                     set_busy;

    function automatic operand_t read_src(logic is_zero, logic is_busy,
                                          logic [XLEN-1:0] value, operand_t rrf_op);
        operand_t op;
        if (is_zero) begin
            op = '{ready: 1'b1, tag: '0, value: '0};
        end else if (!is_busy) begin
            op = '{ready: 1'b1, tag: '0, value: value};
        end else begin
            // in flight, rename file knows if it is done
            op = rrf_op;
        end
        return op;
    endfunction

    assign src1_tag_o = tags[uop_i.rs1];
    assign src2_tag_o = tags[uop_i.rs2];

    assign src1_o = read_src(uop_i.rs1 == '0, busy[uop_i.rs1], regs[uop_i.rs1], rrf_src1_i);
    assign src2_o = read_src(uop_i.rs2 == '0, busy[uop_i.rs2], regs[uop_i.rs2], rrf_src2_i);

    assign set_busy = alloc_i && uop_i.wr_reg && (uop_i.rd != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy <= '0;
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (commit_i.valid && commit_i.wen) begin
                regs[commit_i.rd] <= commit_i.data;
                // a younger rename keeps it busy
                if (tags[commit_i.rd] == head_tag_i) begin
                    busy[commit_i.rd] <= 1'b0;
                end
            end
            if (set_busy) begin
                busy[uop_i.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (set_busy) begin
            tags[uop_i.rd] <= alloc_tag_i;
        end
    end

endmodule

//--- verilog/rename_reg_file.sv
`timescale 1ns/1ps

module rename_reg_file (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        alloc_i,
    input  logic [ooo_pkg::RRF_SEL-1:0] alloc_tag_i,
    input  ooo_pkg::wb_t                wb_i,
    input  logic [ooo_pkg::RRF_SEL-1:0] src1_tag_i,
    input  logic [ooo_pkg::RRF_SEL-1:0] src2_tag_i,
    input  logic [ooo_pkg::RRF_SEL-1:0] head_tag_i,
    output ooo_pkg::operand_t           rrf_src1_o,
    output ooo_pkg::operand_t           rrf_src2_o,
    output logic [ooo_pkg::XLEN-1:0]    head_data_o
);

    import ooo_pkg::*;

    logic [XLEN-1:0]    data [NUM_RRF];
    logic [NUM_RRF-1:0] valid;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid <= '0;
        end else begin
            if (alloc_i) begin
                valid[alloc_tag_i] <= 1'b0;
            end
            if (wb_i.valid) begin
                valid[wb_i.tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wb_i.valid) begin
            data[wb_i.tag] <= wb_i.data;
        end
    end

    assign rrf_src1_o  = '{ready: valid[src1_tag_i], tag: src1_tag_i, value: data[src1_tag_i]};
    assign rrf_src2_o  = '{ready: valid[src2_tag_i], tag: src2_tag_i, value: data[src2_tag_i]};
    assign head_data_o = data[head_tag_i];

endmodule

//--- verilog/alu_station.sv
`timescale 1ns/1ps

module alu_station (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        alloc_i,
    input  ooo_pkg::uop_t               uop_i,
    input  logic [ooo_pkg::RRF_SEL-1:0] alloc_tag_i,
    input  ooo_pkg::operand_t           src1_i,
    input  ooo_pkg::operand_t           src2_i,
    input  ooo_pkg::wb_t                wb_i,
    output logic                        rs_full_o,
    output logic                        issue_o,
    output ooo_pkg::rs_entry_t          issue_entry_o
);

    import ooo_pkg::*;

    rs_entry_t             entries [RS_ENTRIES];
    logic [RS_ENTRIES-1:0] valid;
    logic [RS_ENTRIES-1:0] ready;
    logic [RS_ENTRIES-1:0] oldest;
    // older[i][j] means entry i came in before entry j
    logic [RS_ENTRIES-1:0] older [RS_ENTRIES];
    logic [RS_SEL-1:0]     free_sel;
    logic [RS_SEL-1:0]     issue_sel;
    rs_entry_t             new_entry;

    function automatic operand_t wake(operand_t op, wb_t wb);
        operand_t res;
        res = op;
        if (!op.ready && wb.valid && (wb.tag == op.tag)) begin
            res.ready = 1'b1;
            res.value = wb.data;
        end
        return res;
    endfunction

    always_comb begin
        new_entry.op        = uop_i.op;
        new_entry.src_b_sel = uop_i.src_b_sel;
        new_entry.imm       = uop_i.imm;
        new_entry.src1      = wake(src1_i, wb_i);
        new_entry.src2      = wake(src2_i, wb_i);
        new_entry.dst_tag   = alloc_tag_i;
        // immediate forms never wait on rs2
        if (uop_i.src_b_sel == SRC_B_IMM) begin
            new_entry.src2.ready = 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < RS_ENTRIES; i++) begin
            ready[i] = valid[i] && entries[i].src1.ready && entries[i].src2.ready;
        end
        oldest = ready;
        for (int i = 0; i < RS_ENTRIES; i++) begin
            for (int j = 0; j < RS_ENTRIES; j++) begin
                if (ready[j] && older[j][i]) begin
                    oldest[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        issue_sel = '0;
        free_sel  = '0;
        for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
            if (oldest[i]) begin
                issue_sel = RS_SEL'(i);
            end
            if (!valid[i]) begin
                free_sel = RS_SEL'(i);
            end
        end
    end

    assign rs_full_o     = &valid;
    assign issue_o       = |oldest;
    assign issue_entry_o = entries[issue_sel];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid <= '0;
            for (int i = 0; i < RS_ENTRIES; i++) begin
                older[i] <= '0;
            end
        end else begin
            if (issue_o) begin
                valid[issue_sel] <= 1'b0;
            end
            if (alloc_i) begin
                valid[free_sel] <= 1'b1;
                older[free_sel] <= '0;
                for (int j = 0; j < RS_ENTRIES; j++) begin
                    older[j][free_sel] <= valid[j];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_ENTRIES; i++) begin
            entries[i].src1 <= wake(entries[i].src1, wb_i);
            entries[i].src2 <= wake(entries[i].src2, wb_i);
        end
        if (alloc_i) begin
            entries[free_sel] <= new_entry;
        end
    end

    // dispatch has to hold off while every entry is taken
    a_no_alloc_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        alloc_i |-> !rs_full_o);

endmodule

//--- verilog/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               issue_i,
    input  ooo_pkg::rs_entry_t issue_entry_i,
    output ooo_pkg::wb_t       wb_o
);

    import ooo_pkg::*;

    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    op_b;
    logic [XLEN-1:0]    result;
    logic               wb_valid_q;
    logic [RRF_SEL-1:0] wb_tag_q;
    logic [XLEN-1:0]    wb_data_q;

    assign op_a = issue_entry_i.src1.value;
    assign op_b = (issue_entry_i.src_b_sel == SRC_B_IMM) ? issue_entry_i.imm
                                                         : issue_entry_i.src2.value;

    always_comb begin
        case (issue_entry_i.op)
            ADD:     result = op_a + op_b;
            SUB:     result = op_a - op_b;
            AND:     result = op_a & op_b;
            OR:      result = op_a | op_b;
            XOR:     result = op_a ^ op_b;
            SLL:     result = op_a << op_b[4:0];
            SRL:     result = op_a >> op_b[4:0];
            SLT:     result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= issue_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            wb_tag_q  <= issue_entry_i.dst_tag;
            wb_data_q <= result;
        end
    end

    assign wb_o = '{valid: wb_valid_q, tag: wb_tag_q, data: wb_data_q};

endmodule

//--- verilog/rob_control.sv
`timescale 1ns/1ps

module rob_control (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        dispatch_req_i,
    input  ooo_pkg::uop_t               uop_i,
    input  logic                        rs_full_i,
    input  ooo_pkg::wb_t                wb_i,
    input  logic [ooo_pkg::XLEN-1:0]    rrf_data_i,
    output logic                        dispatch_ack_o,
    output logic                        alloc_o,
    output logic [ooo_pkg::RRF_SEL-1:0] alloc_tag_o,
    output logic [ooo_pkg::RRF_SEL-1:0] head_tag_o,
    output ooo_pkg::commit_t            commit_o
);

    import ooo_pkg::*;

    dispatch_state_e    state;
    logic [RRF_SEL-1:0] head;
    logic [RRF_SEL-1:0] tail;
    logic [RRF_SEL:0]   count;
    logic [NUM_RRF-1:0] done;
    logic [NUM_RRF-1:0] wen_q;
    logic [REG_SEL-1:0] rd_q [NUM_RRF];
    logic               ring_full;
    logic               accept;
    logic               do_commit;
    logic [RRF_SEL-1:0] wb_offset;

    assign ring_full = (count == (RRF_SEL+1)'(NUM_RRF));
    assign accept    = (state == IDLE) && dispatch_req_i && !ring_full && !rs_full_i;
    assign do_commit = (count != '0) && done[head];

    assign dispatch_ack_o = (state == ACKED);
    assign alloc_o        = accept;
    assign alloc_tag_o    = tail;
    assign head_tag_o     = head;

    assign commit_o = '{valid: do_commit,
                        wen:   wen_q[head],
                        rd:    rd_q[head],
                        data:  rrf_data_i};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= IDLE;
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            case (state)
                IDLE:    if (accept) state <= ACKED;
                ACKED:   if (!dispatch_req_i) state <= IDLE;
                default: state <= IDLE;
            endcase
            if (accept) begin
                tail       <= tail + 1'b1;
                done[tail] <= 1'b0;
            end
            if (wb_i.valid) begin
                done[wb_i.tag] <= 1'b1;
            end
            if (do_commit) begin
                head <= head + 1'b1;
            end
            if (accept && !do_commit) begin
                count <= count + 1'b1;
            end else if (!accept && do_commit) begin
                count <= count - 1'b1;
            end
        end
    end

    // retire info for each slot
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rd_q[tail]  <= uop_i.rd;
            wen_q[tail] <= uop_i.wr_reg && (uop_i.rd != '0);
        end
    end

    a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(dispatch_ack_o) |-> $past(dispatch_req_i));

    // a slot becomes done once, from one broadcast, while it is in flight
    assign wb_offset = wb_i.tag - head;

    a_wb_in_flight: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_i.valid |-> ({1'b0, wb_offset} < count) && !done[wb_i.tag]);

endmodule

//--- verilog/ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             dispatch_req_i,
    input  ooo_pkg::uop_t    uop_i,
    output logic             dispatch_ack_o,
    output ooo_pkg::commit_t commit_o
);

    import ooo_pkg::*;

    logic               rs_full;
    logic               alloc;
    logic [RRF_SEL-1:0] alloc_tag;
    logic [RRF_SEL-1:0] head_tag;
    logic [XLEN-1:0]    head_data;
    logic [RRF_SEL-1:0] src1_tag;
    logic [RRF_SEL-1:0] src2_tag;
    operand_t           rrf_src1;
    operand_t           rrf_src2;
    operand_t           src1;
    operand_t           src2;
    logic               issue;
    rs_entry_t          issue_entry;
    wb_t                wb;

    rob_control u_rob_control (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .dispatch_req_i (dispatch_req_i),
        .uop_i          (uop_i),
        .rs_full_i      (rs_full),
        .wb_i           (wb),
        .rrf_data_i     (head_data),
        .dispatch_ack_o (dispatch_ack_o),
        .alloc_o        (alloc),
        .alloc_tag_o    (alloc_tag),
        .head_tag_o     (head_tag),
        .commit_o       (commit_o)
    );

    arch_reg_file u_arch_reg_file (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .alloc_i     (alloc),
        .uop_i       (uop_i),
        .alloc_tag_i (alloc_tag),
        .commit_i    (commit_o),
        .head_tag_i  (head_tag),
        .rrf_src1_i  (rrf_src1),
        .rrf_src2_i  (rrf_src2),
        .src1_tag_o  (src1_tag),
        .src2_tag_o  (src2_tag),
        .src1_o      (src1),
        .src2_o      (src2)
    );

    rename_reg_file u_rename_reg_file (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .alloc_i     (alloc),
        .alloc_tag_i (alloc_tag),
        .wb_i        (wb),
        .src1_tag_i  (src1_tag),
        .src2_tag_i  (src2_tag),
        .head_tag_i  (head_tag),
        .rrf_src1_o  (rrf_src1),
        .rrf_src2_o  (rrf_src2),
        .head_data_o (head_data)
    );

    alu_station u_alu_station (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .alloc_i       (alloc),
        .uop_i         (uop_i),
        .alloc_tag_i   (alloc_tag),
        .src1_i        (src1),
        .src2_i        (src2),
        .wb_i          (wb),
        .rs_full_o     (rs_full),
        .issue_o       (issue),
        .issue_entry_o (issue_entry)
    );

    alu_unit u_alu_unit (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .issue_i       (issue),
        .issue_entry_i (issue_entry),
        .wb_o          (wb)
    );

endmodule

//--- verification/ooo_core_tb_tasks.svh
function automatic uop_t build_uop(alu_op_e op, int rd, int rs1, int rs2,
                                   src_b_sel_e src_b_sel, logic [XLEN-1:0] imm,
                                   logic wr_reg);
    uop_t u;
    u.op        = op;
    u.rd        = REG_SEL'(rd);
    u.rs1       = REG_SEL'(rs1);
    u.rs2       = REG_SEL'(rs2);
    u.src_b_sel = src_b_sel;
    u.imm       = imm;
    u.wr_reg    = wr_reg;
    return u;
endfunction

// result in program order from the model registers
function automatic logic [XLEN-1:0] compute_result(uop_t u);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] r;
    a = model_regs[u.rs1];
    if (u.src_b_sel == SRC_B_IMM) begin
        b = u.imm;
    end else begin
        b = model_regs[u.rs2];
    end
    case (u.op)
        ADD:     r = a + b;
        SUB:     r = a - b;
        AND:     r = a & b;
        OR:      r = a | b;
        XOR:     r = a ^ b;
        SLL:     r = a << b[4:0];
        SRL:     r = a >> b[4:0];
        SLT:     r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default: r = 'x;
    endcase
    return r;
endfunction

task automatic compare_commit(commit_t actual, commit_t expected);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("ERR %0t: commit wen %b rd %0d data %h, expected wen %b rd %0d data %h",
                 $time, actual.wen, actual.rd, actual.data,
                 expected.wen, expected.rd, expected.data);
    end
endtask

task automatic compare_ack(logic actual, logic expected, string what);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("ERR %0t: %s is %b, expected %b", $time, what, actual, expected);
    end
endtask

// four-phase handshake, entered and left just after a rising edge
task automatic send_uop(uop_t u);
    commit_t exp_c;
    int      waited;
    exp_c.valid = 1'b1;
    exp_c.wen   = u.wr_reg && (u.rd != '0);
    exp_c.rd    = u.rd;
    exp_c.data  = compute_result(u);
    exp_q.push_back(exp_c);
    if (exp_c.wen) begin
        model_regs[u.rd] = exp_c.data;
    end
    compare_ack(dispatch_ack_o, 1'b0, "ack before req");
    uop_i          = u;
    dispatch_req_i = 1'b1;
    waited         = 0;
    do begin
        @(posedge clk_i);
        #DRIVE_DLY;
        waited++;
    end while (dispatch_ack_o !== 1'b1 && waited < ACK_LIMIT);
    if (dispatch_ack_o !== 1'b1) begin
        errors++;
        $display("uop %0d was never acknowledged within %0d cycles", sent, ACK_LIMIT);
    end
    dispatch_req_i = 1'b0;
    waited         = 0;
    do begin
        @(posedge clk_i);
        #DRIVE_DLY;
        waited++;
    end while (dispatch_ack_o !== 1'b0 && waited < ACK_LIMIT);
    if (dispatch_ack_o !== 1'b0) begin
        errors++;
        $display("ack of uop %0d stayed high after req was dropped", sent);
    end
    sent++;
endtask

task automatic wait_drain(string what);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
        @(posedge clk_i);
        #DRIVE_DLY;
        waited++;
    end
    if (exp_q.size() != 0) begin
        errors++;
        $display("%s: %0d uops never committed within %0d cycles",
                 what, exp_q.size(), DRAIN_LIMIT);
        exp_q.delete();
    end
endtask

//--- verification/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb;

    import ooo_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;
    localparam int ACK_LIMIT   = 200;
    localparam int DRAIN_LIMIT = 400;
    localparam int BURST_LEN   = 20;
    localparam int NUM_RANDOM  = 200;
    localparam int TOTAL_UOPS  = 10 + 8 + 5 + BURST_LEN + NUM_RANDOM;

    logic    clk_i;
    logic    arst_n_i;
    logic    dispatch_req_i;
    uop_t    uop_i;
    logic    dispatch_ack_o;
    commit_t commit_o;

    logic [XLEN-1:0] model_regs [NUM_ARCH_REGS];
    commit_t         exp_q [$];
    commit_t         head_exp;
    int              errors  = 0;
    int              checks  = 0;
    int              sent    = 0;
    int              commits = 0;
    logic            req_prev = 1'b0;
    logic            ack_prev = 1'b0;

    `include "ooo_core_tb_tasks.svh"

    ooo_core_top uut (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .dispatch_req_i (dispatch_req_i),
        .uop_i          (uop_i),
        .dispatch_ack_o (dispatch_ack_o),
        .commit_o       (commit_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // retirement order against the model queue
    always @(negedge clk_i) begin
        if (arst_n_i && commit_o.valid === 1'b1) begin
            commits++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("a commit of rd %0d came with no uop outstanding", commit_o.rd);
            end else begin
                head_exp = exp_q.pop_front();
                compare_commit(commit_o, head_exp);
            end
        end
    end

    // ack may only change to the level req held before the edge
    always @(negedge clk_i) begin
        if (arst_n_i && dispatch_ack_o !== ack_prev) begin
            compare_ack(dispatch_ack_o, req_prev, "ack after its edge");
        end
        req_prev = dispatch_req_i;
        ack_prev = dispatch_ack_o;
    end

    initial begin
        #(TOTAL_UOPS * 30 * CLK_PERIOD);
        errors++;
        $display("watchdog expired after %0d ns, the tests did not finish",
                 TOTAL_UOPS * 30 * CLK_PERIOD);
        finish_run();
    end

    task automatic finish_run();
        $display("checks %0d, errors %0d, uops sent %0d, commits seen %0d",
                 checks, errors, sent, commits);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic test_reset_idle();
        repeat (8) begin
            compare_ack(dispatch_ack_o, 1'b0, "ack after reset");
            if (commit_o.valid !== 1'b0) begin
                errors++;
                $display("ERR %0t: commit valid high before any request", $time);
            end
            @(posedge clk_i);
            #DRIVE_DLY;
        end
    endtask

    task automatic test_imm_ops();
        alu_op_e op;
        send_uop(build_uop(ADD, 1, 0, 0, SRC_B_IMM, 32'h1234_5678, 1'b1));
        send_uop(build_uop(ADD, 2, 0, 0, SRC_B_IMM, 32'hFFFF_FFFB, 1'b1));
        for (int i = 0; i < 8; i++) begin
            op = alu_op_e'(i);
            // r2 is negative, so SLT only passes as a signed compare
            send_uop(build_uop(op, 3 + i, (op == SLT) ? 2 : 1, 0, SRC_B_IMM,
                               32'h0F0F_00F3 + 32'(i) * 32'h0101_0107, 1'b1));
        end
        wait_drain("immediate ops");
    endtask

    task automatic test_dependency_chain();
        send_uop(build_uop(ADD, 4, 1, 2, SRC_B_REG, '0, 1'b1));
        send_uop(build_uop(XOR, 4, 4, 0, SRC_B_IMM, 32'h00FF_00FF, 1'b1));
        send_uop(build_uop(SUB, 4, 4, 1, SRC_B_REG, '0, 1'b1));
        send_uop(build_uop(SUB, 5, 4, 2, SRC_B_REG, '0, 1'b1));
        send_uop(build_uop(AND, 6, 5, 4, SRC_B_REG, '0, 1'b1));
        send_uop(build_uop(OR, 7, 6, 1, SRC_B_REG, '0, 1'b1));
        send_uop(build_uop(SLL, 8, 7, 2, SRC_B_REG, '0, 1'b1));
        send_uop(build_uop(SRL, 9, 4, 0, SRC_B_IMM, 32'd4, 1'b1));
        wait_drain("dependency chain");
    endtask

    task automatic test_r0_writes();
        send_uop(build_uop(ADD, 0, 1, 0, SRC_B_IMM, 32'd7, 1'b1));
        send_uop(build_uop(XOR, 10, 0, 0, SRC_B_IMM, 32'h55, 1'b1));
        send_uop(build_uop(OR, 11, 0, 0, SRC_B_REG, '0, 1'b1));
        // no register write requested
        send_uop(build_uop(ADD, 12, 1, 0, SRC_B_IMM, 32'd1, 1'b0));
        send_uop(build_uop(SUB, 13, 12, 0, SRC_B_REG, '0, 1'b1));
        wait_drain("r0 writes");
    endtask

    task automatic test_burst();
        int start_commits;
        start_commits = commits;
        for (int i = 0; i < BURST_LEN; i++) begin
            send_uop(build_uop(alu_op_e'(i % 8), 1 + (i % 4), 1 + ((i + 1) % 4),
                               1 + ((i + 2) % 4), src_b_sel_e'(i % 2), 32'(i * 3 + 1), 1'b1));
        end
        wait_drain("burst");
        checks++;
        if (commits - start_commits != BURST_LEN) begin
            errors++;
            $display("ERR %0t: burst gave %0d commits, expected %0d",
                     $time, commits - start_commits, BURST_LEN);
        end
    endtask

    task automatic test_random();
        uop_t u;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            u           = '0;
            u.op        = alu_op_e'($urandom % 8);
            u.rd        = REG_SEL'($urandom % 8);
            u.rs1       = REG_SEL'($urandom % 8);
            u.rs2       = REG_SEL'($urandom % 8);
            u.src_b_sel = src_b_sel_e'($urandom % 2);
            u.imm       = $urandom;
            u.wr_reg    = ($urandom % 8) != 0;
            send_uop(u);
        end
        wait_drain("random uops");
    endtask

    initial begin
        arst_n_i       = 1'b0;
        dispatch_req_i = 1'b0;
        uop_i          = '0;
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(41995));
        repeat (4) @(posedge clk_i);
        #DRIVE_DLY;
        arst_n_i = 1'b1;
        test_reset_idle();
        test_imm_ops();
        test_dependency_chain();
        test_r0_writes();
        test_burst();
        test_random();
        finish_run();
    end

endmodule

//--- filelist.f
+incdir+verification
verilog/ooo_pkg.sv
verilog/arch_reg_file.sv
verilog/rename_reg_file.sv
verilog/alu_station.sv
verilog/alu_unit.sv
verilog/rob_control.sv
verilog/ooo_core_top.sv
verification/ooo_core_tb.sv

//--- run.sh
#!/bin/sh
# build the ooo core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module ooo_core_tb -o ooo_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/ooo_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1
